//--- common/alu_pkg.sv
/* ALU control encodings, control word struct and pipeline
   latency constants */

`default_nettype none

package alu_pkg;

    // -------------------------------------------------------------------------
    // Control encodings
    // -------------------------------------------------------------------------

    // Adder mode, bit 0 of the control word
    typedef enum logic {
        ADD = 1'b0,
        SUB = 1'b1
    } add_sub_e;

    // Logic stage function
    typedef enum logic [2:0] {
        LOGIC_PASS_ADDSUB = 3'd0,  // Add/sub result straight through
        LOGIC_AND         = 3'd1,
        LOGIC_OR          = 3'd2,
        LOGIC_XOR         = 3'd3,
        LOGIC_NOT_A       = 3'd4,
        LOGIC_PASS_A      = 3'd5,
        LOGIC_PASS_B      = 3'd6,
        LOGIC_XNOR        = 3'd7
    } logic_op_e;

    // Control word as presented with the operands
    typedef struct packed {
        logic_op_e logic_op;  // Bits [3:1]
        add_sub_e  add_sub;   // Bit 0
    } alu_control_t;

    // -------------------------------------------------------------------------
    // Latencies, in clock edges
    // -------------------------------------------------------------------------

    localparam int ADD_SUB_LATENCY = 2;  // Operand reg + sum reg
    localparam int BITWISE_LATENCY = 1;

    // Add/sub, logic, then one output register
    localparam int ALU_LATENCY = ADD_SUB_LATENCY + BITWISE_LATENCY + 1;

endpackage

`default_nettype wire

//--- hw/delay_line.sv
/* Shift-register delay line with synchronous clear */

`timescale 1ns/1ps
`default_nettype none

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    logic [WIDTH-1:0] stage [DEPTH];  // stage[0] sits next to the input

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];  // Shift one step per edge
            end
        end
    end

    assign out = stage[DEPTH-1];

endmodule

`default_nettype wire

//--- hw/alu/add_sub.sv
/* Two-stage registered adder/subtractor, operands registered
   first, then the sum */

`timescale 1ns/1ps
`default_nettype none

module add_sub #(
    parameter int WORD_WIDTH = 36
) (
    input  logic                  clock,
    input  logic                  rst,
    input  alu_pkg::add_sub_e     add_sub,
    input  logic [WORD_WIDTH-1:0] a,
    input  logic [WORD_WIDTH-1:0] b,
    output logic [WORD_WIDTH-1:0] result
);

    // Sum registers that follow the operand register
    localparam int SUM_STAGES = alu_pkg::ADD_SUB_LATENCY - 1;

    alu_pkg::add_sub_e     mode_q;
    logic [WORD_WIDTH-1:0] a_q;
    logic [WORD_WIDTH-1:0] b_q;
    logic [WORD_WIDTH-1:0] b_eff;
    logic                  carry_in;
    logic [WORD_WIDTH-1:0] sum;
    logic [WORD_WIDTH-1:0] sum_q [SUM_STAGES];

    // Stage one
    always_ff @(posedge clock) begin
        if (rst) begin
            mode_q <= alu_pkg::ADD;
            a_q    <= '0;
            b_q    <= '0;
        end else begin
            mode_q <= add_sub;
            a_q    <= a;
            b_q    <= b;
        end
    end

    // Subtract as A + ~B + 1
    always_comb begin
        b_eff    = (mode_q == alu_pkg::SUB) ? ~b_q : b_q;
        carry_in = (mode_q == alu_pkg::SUB);
        sum      = a_q + b_eff + WORD_WIDTH'(carry_in);  // Carry out dropped
    end

    // Stage two
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < SUM_STAGES; i++) begin
                sum_q[i] <= '0;
            end
        end else begin
            sum_q[0] <= sum;
            for (int i = 1; i < SUM_STAGES; i++) begin
                sum_q[i] <= sum_q[i-1];
            end
        end
    end

    assign result = sum_q[SUM_STAGES-1];

endmodule

`default_nettype wire

//--- hw/alu/bitwise.sv
/* Registered logic unit combining A, B and the add/sub result
   under a logic opcode */

`timescale 1ns/1ps
`default_nettype none

module bitwise #(
    parameter int WORD_WIDTH = 36
) (
    input  logic                  clock,
    input  logic                  rst,
    input  alu_pkg::logic_op_e    op,
    input  logic [WORD_WIDTH-1:0] result_add_sub,
    input  logic [WORD_WIDTH-1:0] a,
    input  logic [WORD_WIDTH-1:0] b,
    output logic [WORD_WIDTH-1:0] r
);

    localparam int STAGES = alu_pkg::BITWISE_LATENCY;

    logic [WORD_WIDTH-1:0] r_next;
    logic [WORD_WIDTH-1:0] r_q [STAGES];

    // -------------------------------------------------------------------------
    // Function select
    // -------------------------------------------------------------------------

    always_comb begin
        case (op)
            alu_pkg::LOGIC_PASS_ADDSUB: begin
                r_next = result_add_sub;
            end
            alu_pkg::LOGIC_AND: begin
                r_next = a & b;
            end
            alu_pkg::LOGIC_OR: begin
                r_next = a | b;
            end
            alu_pkg::LOGIC_XOR: begin
                r_next = a ^ b;
            end
            alu_pkg::LOGIC_NOT_A: begin
                r_next = ~a;
            end
            alu_pkg::LOGIC_PASS_A: begin
                r_next = a;
            end
            alu_pkg::LOGIC_PASS_B: begin
                r_next = b;
            end
            alu_pkg::LOGIC_XNOR: begin
                r_next = ~(a ^ b);
            end
            default: begin
                r_next = result_add_sub;  // Unknown op acts as pass
            end
        endcase
    end

    // -------------------------------------------------------------------------
    // Output register
    // -------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                r_q[i] <= '0;
            end
        end else begin
            r_q[0] <= r_next;
            for (int i = 1; i < STAGES; i++) begin
                r_q[i] <= r_q[i-1];
            end
        end
    end

    assign r = r_q[STAGES-1];

endmodule

`default_nettype wire

//--- hw/alu/alu.sv
/* ALU top level: add/sub, logic unit, operand alignment,
   D operand and valid tag pipeline, output register */

`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int WORD_WIDTH      = 36,
    parameter int D_OPERAND_WIDTH = 10
) (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              in_valid,
    input  alu_pkg::alu_control_t             control,
    input  logic        [D_OPERAND_WIDTH-1:0] d_in,
    input  logic        [WORD_WIDTH-1:0]      a,
    input  logic        [WORD_WIDTH-1:0]      b,
    output logic                              out_valid,
    output logic        [D_OPERAND_WIDTH-1:0] d_out,
    output logic signed [WORD_WIDTH-1:0]      r
);

    localparam int TAG_WIDTH   = D_OPERAND_WIDTH + 1;
    localparam int OP_WIDTH    = $bits(alu_pkg::logic_op_e);
    localparam int OUT_LATENCY = alu_pkg::ALU_LATENCY - alu_pkg::ADD_SUB_LATENCY
                                 - alu_pkg::BITWISE_LATENCY;

    logic [TAG_WIDTH-1:0]  tag_in;
    logic [TAG_WIDTH-1:0]  tag_out;
    logic [WORD_WIDTH-1:0] result_add_sub;
    logic [OP_WIDTH-1:0]   op_delayed;
    alu_pkg::logic_op_e    op_bitwise;
    logic [WORD_WIDTH-1:0] a_bitwise;
    logic [WORD_WIDTH-1:0] b_bitwise;
    logic [WORD_WIDTH-1:0] result_bitwise;

    // -------------------------------------------------------------------------
    // Tag path: valid and D operand ride alongside the data
    // -------------------------------------------------------------------------

    assign tag_in = {in_valid, d_in};

    delay_line #(
        .DEPTH (alu_pkg::ALU_LATENCY),
        .WIDTH (TAG_WIDTH)
    ) tag_pipeline (
        .clock (clock),
        .rst   (rst),
        .in    (tag_in),
        .out   (tag_out)
    );

    assign out_valid = tag_out[TAG_WIDTH-1];       // Valid in the MSB
    assign d_out     = tag_out[D_OPERAND_WIDTH-1:0];

    // -------------------------------------------------------------------------
    // Add/sub with operands and logic op delayed to match
    // -------------------------------------------------------------------------

    add_sub #(
        .WORD_WIDTH (WORD_WIDTH)
    ) add_sub_unit (
        .clock   (clock),
        .rst     (rst),
        .add_sub (control.add_sub),  // Mode used right away
        .a       (a),
        .b       (b),
        .result  (result_add_sub)
    );

    delay_line #(
        .DEPTH (alu_pkg::ADD_SUB_LATENCY),
        .WIDTH (OP_WIDTH)
    ) control_pipeline (
        .clock (clock),
        .rst   (rst),
        .in    (control.logic_op),
        .out   (op_delayed)
    );

    assign op_bitwise = alu_pkg::logic_op_e'(op_delayed);

    delay_line #(
        .DEPTH (alu_pkg::ADD_SUB_LATENCY),
        .WIDTH (WORD_WIDTH)
    ) a_pipeline (
        .clock (clock),
        .rst   (rst),
        .in    (a),
        .out   (a_bitwise)
    );

    delay_line #(
        .DEPTH (alu_pkg::ADD_SUB_LATENCY),
        .WIDTH (WORD_WIDTH)
    ) b_pipeline (
        .clock (clock),
        .rst   (rst),
        .in    (b),
        .out   (b_bitwise)
    );

    // -------------------------------------------------------------------------
    // Logic unit and output register
    // -------------------------------------------------------------------------

    bitwise #(
        .WORD_WIDTH (WORD_WIDTH)
    ) bitwise_unit (
        .clock          (clock),
        .rst            (rst),
        .op             (op_bitwise),
        .result_add_sub (result_add_sub),
        .a              (a_bitwise),
        .b              (b_bitwise),
        .r              (result_bitwise)
    );

    delay_line #(
        .DEPTH (OUT_LATENCY),
        .WIDTH (WORD_WIDTH)
    ) result_pipeline (
        .clock (clock),
        .rst   (rst),
        .in    (result_bitwise),
        .out   (r)
    );

endmodule

`default_nettype wire

//--- verification/alu_tb.sv
/* ALU testbench: random stimulus, reference model queues,
   value checks, watchdog and per-test reporting */

`timescale 1ns/1ps
`default_nettype none

module alu_tb;

    localparam int WORD_WIDTH       = 36;
    localparam int D_WIDTH          = 10;
    localparam int CLOCK_PERIOD     = 8;
    localparam int RESET_CYCLES     = 16;
    localparam int NUM_ADD_SUB      = 200;
    localparam int NUM_LOGIC        = 200;
    localparam int NUM_DUTY_CYCLES  = 300;
    localparam int NUM_ALIGN_CYCLES = 100;
    localparam int DRAIN_CYCLES     = alu_pkg::ALU_LATENCY + 1;
    localparam int MARGIN_CYCLES    = 100;
    localparam int TIMEOUT_CYCLES   = RESET_CYCLES + alu_pkg::ALU_LATENCY + NUM_ADD_SUB
                                      + NUM_LOGIC + NUM_DUTY_CYCLES + NUM_ALIGN_CYCLES
                                      + 4 * DRAIN_CYCLES + MARGIN_CYCLES;

    logic                  clock;
    logic                  rst;
    logic                  in_valid;
    alu_pkg::alu_control_t control;
    logic [D_WIDTH-1:0]    d_in;
    logic [WORD_WIDTH-1:0] a;
    logic [WORD_WIDTH-1:0] b;
    logic                  out_valid;
    logic [D_WIDTH-1:0]    d_out;
    logic [WORD_WIDTH-1:0] r;  // Unsigned view of the signed result

    integer seed = 35963;
    int     cycle = 0;         // Falling edges seen so far
    int     errors = 0;
    int     tests_run = 0;
    int     tests_passed = 0;

    // Expected outputs, oldest first
    logic [D_WIDTH-1:0]    exp_d_q [$];
    logic [WORD_WIDTH-1:0] exp_r_q [$];
    int                    due_q [$];

    alu #(
        .WORD_WIDTH      (WORD_WIDTH),
        .D_OPERAND_WIDTH (D_WIDTH)
    ) DUT (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .control   (control),
        .d_in      (d_in),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .d_out     (d_out),
        .r         (r)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // ------------------------------------------------------------------------
    // Model and random helpers
    // ------------------------------------------------------------------------

    function automatic logic [WORD_WIDTH-1:0] model_result(input alu_pkg::alu_control_t ctrl,
                                                          input logic [WORD_WIDTH-1:0] av,
                                                          input logic [WORD_WIDTH-1:0] bv);
        logic [63:0] mask;
        logic [63:0] wa;
        logic [63:0] wb;
        logic [63:0] s;
        logic [63:0] res;
        mask = (64'd1 << WORD_WIDTH) - 64'd1;
        wa   = 64'(av);
        wb   = 64'(bv);
        s    = (ctrl.add_sub == alu_pkg::SUB) ? wa - wb : wa + wb;
        case (ctrl.logic_op)
            alu_pkg::LOGIC_PASS_ADDSUB: res = s;
            alu_pkg::LOGIC_AND:         res = wa & wb;
            alu_pkg::LOGIC_OR:          res = wa | wb;
            alu_pkg::LOGIC_XOR:         res = wa ^ wb;
            alu_pkg::LOGIC_NOT_A:       res = ~wa;
            alu_pkg::LOGIC_PASS_A:      res = wa;
            alu_pkg::LOGIC_PASS_B:      res = wb;
            alu_pkg::LOGIC_XNOR:        res = ~(wa ^ wb);
            default:                    res = 64'd0;
        endcase
        res = res & mask;  // Modulo 2**WORD_WIDTH
        return res[WORD_WIDTH-1:0];
    endfunction

    function automatic logic [WORD_WIDTH-1:0] rand_word();
        logic [63:0] x;
        x = {$random(seed), $random(seed)};
        return x[WORD_WIDTH-1:0];
    endfunction

    // Zero and all-ones show up now and then for wraparound
    function automatic logic [WORD_WIDTH-1:0] random_operand();
        logic [31:0] roll;
        roll = $random(seed);
        case (roll[2:0])
            3'd0:    return '0;
            3'd1:    return '1;
            default: return rand_word();
        endcase
    endfunction

    function automatic alu_pkg::alu_control_t random_control();
        logic [31:0]           roll;
        alu_pkg::alu_control_t ctrl;
        roll          = $random(seed);
        ctrl.logic_op = alu_pkg::logic_op_e'(roll[3:1]);
        ctrl.add_sub  = alu_pkg::add_sub_e'(roll[0]);
        return ctrl;
    endfunction

    function automatic logic random_valid(input int percent);
        logic [31:0] roll;
        roll = $random(seed);
        return (roll % 32'd100) < 32'(percent);
    endfunction

    // ------------------------------------------------------------------------
    // Checking and driving
    // ------------------------------------------------------------------------

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    // One cycle: check the outputs, then drive the next inputs
    task automatic step(input logic valid, input alu_pkg::alu_control_t ctrl,
                        input logic [D_WIDTH-1:0] d, input logic [WORD_WIDTH-1:0] av,
                        input logic [WORD_WIDTH-1:0] bv);
        logic expect_out;
        @(negedge clock);
        cycle++;
        expect_out = 1'b0;
        if (due_q.size() > 0) begin
            expect_out = (due_q[0] == cycle);
        end
        check_value(64'(out_valid), 64'(expect_out), "out_valid");
        if (expect_out) begin
            check_value(64'(d_out), 64'(exp_d_q[0]), "d_out");
            check_value(64'(r), 64'(exp_r_q[0]), $sformatf("r for d_in %0h", exp_d_q[0]));
            void'(due_q.pop_front());
            void'(exp_d_q.pop_front());
            void'(exp_r_q.pop_front());
        end
        in_valid = valid;
        control  = ctrl;
        d_in     = d;
        a        = av;
        b        = bv;
        if (valid) begin
            exp_d_q.push_back(d);
            exp_r_q.push_back(model_result(ctrl, av, bv));
            due_q.push_back(cycle + alu_pkg::ALU_LATENCY);  // Out after the fourth edge
        end
    endtask

    task automatic drain();
        repeat (DRAIN_CYCLES) begin
            step(1'b0, random_control(), D_WIDTH'($random(seed)), rand_word(), rand_word());
        end
        check_value(64'(due_q.size()), 64'd0, "model queue empty after drain");
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
        end
        $display("Test %0d %-18s done, %0d errors", tests_run, name, errors - errors_before);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    task automatic run_reset_test();
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            if (i < RESET_CYCLES - 1) begin
                // Busy inputs that the reset must keep away from the outputs
                step(1'b0, random_control(), D_WIDTH'($random(seed)), rand_word(),
                     rand_word());
                in_valid = 1'b1;
            end else begin
                step(1'b0, '0, '0, '0, '0);  // Quiet inputs for the first edge out of reset
            end
            check_value(64'(r), 64'd0, "r during reset");
            check_value(64'(d_out), 64'd0, "d_out during reset");
        end
        rst = 1'b0;
        repeat (alu_pkg::ALU_LATENCY) begin
            step(1'b0, '0, '0, '0, '0);
            check_value(64'(r), 64'd0, "r after reset");
            check_value(64'(d_out), 64'd0, "d_out after reset");
        end
        finish_test("reset", errors_before);
    endtask

    task automatic run_add_sub_test();
        int                    errors_before;
        alu_pkg::alu_control_t ctrl;
        logic [WORD_WIDTH-1:0] av;
        logic [WORD_WIDTH-1:0] bv;
        errors_before = errors;
        for (int i = 0; i < NUM_ADD_SUB; i++) begin
            ctrl          = random_control();  // Random mode
            ctrl.logic_op = alu_pkg::LOGIC_PASS_ADDSUB;
            if (i < 8) begin  // Every zero/all-ones pair in both modes
                av           = i[1] ? '1 : '0;
                bv           = i[0] ? '1 : '0;
                ctrl.add_sub = alu_pkg::add_sub_e'(i[2]);
            end else begin
                av           = random_operand();
                bv           = random_operand();
            end
            step(1'b1, ctrl, D_WIDTH'($random(seed)), av, bv);
        end
        drain();
        finish_test("add_sub", errors_before);
    endtask

    task automatic run_logic_test();
        int                    errors_before;
        alu_pkg::alu_control_t ctrl;
        errors_before = errors;
        for (int i = 0; i < NUM_LOGIC; i++) begin
            ctrl          = random_control();
            ctrl.logic_op = alu_pkg::logic_op_e'(i[2:0]);  // Cycle through all ops
            step(1'b1, ctrl, D_WIDTH'($random(seed)), random_operand(), random_operand());
        end
        drain();
        finish_test("logic_ops", errors_before);
    endtask

    task automatic run_duty_test(input string name, input int cycles, input int percent);
        int errors_before;
        errors_before = errors;
        repeat (cycles) begin
            step(random_valid(percent), random_control(), D_WIDTH'($random(seed)),
                 rand_word(), rand_word());
        end
        drain();
        finish_test(name, errors_before);
    endtask

    initial begin
        clock    = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        control  = '0;
        d_in     = '0;
        a        = '0;
        b        = '0;
        run_reset_test();
        run_add_sub_test();
        run_logic_test();
        run_duty_test("latency_duty", NUM_DUTY_CYCLES, 70);
        run_duty_test("d_alignment", NUM_ALIGN_CYCLES, 50);
        $display("Tests passed: %0d of %0d, errors: %0d", tests_passed, tests_run, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized from the test lengths
    initial begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the tests did not finish after %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/alu_pkg.sv
hw/delay_line.sv
hw/alu/add_sub.sv
hw/alu/bitwise.sv
hw/alu/alu.sv
verification/alu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the ALU testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module alu_tb \
    --Mdir obj_dir \
    -f build.f \
    || { echo "Verilator build failed"; exit 1; }

output="$(./obj_dir/Valu_tb 2>&1)"
echo "$output"

echo "$output" | grep -qxF '>>> PASS' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

exit 0
